// File: src/rs_pkg.sv
// Issue stage sizes, unit kinds and slot map, register tag, row and CDB types
package rs_pkg;

	//////////////////////////////
	// Sizes
	//////////////////////////////

	// Dispatch lanes, also the CDB lane count
	localparam int SS_SIZE = 2;

	// Rows in the unified station
	localparam int RS_SIZE = 8;
	localparam int ROW_IDX_W = $clog2(RS_SIZE);
	// Free count runs 0 to RS_SIZE inclusive
	localparam int FREE_W = $clog2(RS_SIZE + 1);

	// Physical register file
	localparam int NUM_PHYS_REG = 32;
	localparam int TAG_W = $clog2(NUM_PHYS_REG);

	// Issue slots and unit kinds
	localparam int NUM_FU_TOTAL = 5;
	localparam int NUM_FU_TYPE = 4;

	//////////////////////////////
	// Functional units
	//////////////////////////////

	typedef enum logic [1:0] {
		FU_ALU  = 2'd0,
		FU_LD   = 2'd1,
		FU_MULT = 2'd2,
		FU_BR   = 2'd3
	} fu_type_e;

	// First issue slot of each kind, indexed by fu_type_e
	localparam int FU_BASE_IDX [NUM_FU_TYPE] = '{0, 2, 3, 4};
	// Slots per kind, two ALUs and one of each other
	localparam int FU_COUNT [NUM_FU_TYPE] = '{2, 1, 1, 1};

	//////////////////////////////
	// Tags and rows
	//////////////////////////////

	typedef logic [TAG_W-1:0] phys_reg_t;

	// Source operand tag with its ready flag on top
	typedef struct packed {
		logic      ready;
		phys_reg_t idx;
	} phys_tag_t;

	// One station row, also the dispatch and issue payload
	typedef struct packed {
		logic       busy;
		fu_type_e   fu;
		logic [3:0] op;
		phys_reg_t  dest;
		phys_tag_t  t1;
		phys_tag_t  t2;
		logic       valid_inst;
	} rs_row_t;

	localparam rs_row_t EMPTY_ROW = '0;

	// One lane of the result broadcast
	typedef struct packed {
		logic      valid;
		phys_reg_t tag;
	} cdb_t;

endpackage

// File: src/psel_generic.sv
// Multi-grant priority selector, lowest request index wins each round
`timescale 1ns/1ps

module psel_generic #(
	parameter int WIDTH    = 8,
	parameter int NUM_REQS = 2
) (
	input  logic [WIDTH-1:0]                          req,
	input  logic                                      en,
	// Union of every round's grant
	output logic [WIDTH-1:0]                          gnt,
	// Round r grant as a row index
	output logic [NUM_REQS-1:0][$clog2(WIDTH)-1:0]   gnt_idx,
	output logic [NUM_REQS-1:0]                       gnt_valid
);

	//////////////////////////////
	// Grant rounds
	//////////////////////////////

	// Each round takes the lowest remaining request
	// and removes it before the next round looks
	always_comb begin
		logic [WIDTH-1:0]         left;
		logic [$clog2(WIDTH)-1:0] pick;
		logic                     found;

		// Disabled selector grants nothing
		left = en ? req : '0;
		gnt = '0;

		for (int r = 0; r < NUM_REQS; r++) begin
			pick = '0;
			found = 1'b0;

			// Scan from the top so the lowest set bit is kept last
			for (int i = WIDTH - 1; i >= 0; i--) begin
				if (left[i]) begin
					pick = i[$clog2(WIDTH)-1:0];
					found = 1'b1;
				end
			end

			gnt_idx[r] = pick;
			gnt_valid[r] = found;

			// Granted requester drops out of later rounds
			if (found) begin
				left[pick] = 1'b0;
				gnt[pick] = 1'b1;
			end
		end
	end

	// Fewer requests than rounds leaves the top rounds invalid
	// with index zero

endmodule

// File: src/tag_cam.sv
// Tag CAM matching broadcast result tags against both sources of every row
`timescale 1ns/1ps

module tag_cam #(
	parameter int LENGTH   = 8,
	parameter int NUM_TAGS = 2
) (
	// Per-lane broadcast valid
	input  logic [NUM_TAGS-1:0]                     cam_en,
	input  rs_pkg::phys_reg_t [NUM_TAGS-1:0]        tags,
	// Two source tags per table entry
	input  rs_pkg::phys_reg_t [LENGTH-1:0][1:0]     table_tags,
	// One hit per source, any lane
	output logic [LENGTH-1:0][1:0]                  hits
);

	//////////////////////////////
	// Compare array
	//////////////////////////////

	// Full LENGTH x 2 x NUM_TAGS comparator grid
	always_comb begin
		for (int r = 0; r < LENGTH; r++) begin
			// Source 0 then source 1
			for (int o = 0; o < 2; o++) begin
				hits[r][o] = 1'b0;

				// OR across enabled lanes
				for (int l = 0; l < NUM_TAGS; l++) begin
					if (cam_en[l] && (tags[l] == table_tags[r][o])) begin
						hits[r][o] = 1'b1;
					end
				end
			end
		end
	end

	// Stale entries also compare, the caller masks by row state

endmodule

// File: src/reservation_station.sv
// Unified reservation station with dispatch placement, CDB wakeup, typed issue and flush
`timescale 1ns/1ps

module reservation_station (
	input  logic                                          clock,
	input  logic                                          rst_n,
	// Dispatch permission from the reorder buffer
	input  logic                                          enable,
	input  logic [rs_pkg::SS_SIZE-1:0]                    dispatch_valid,
	input  rs_pkg::rs_row_t [rs_pkg::SS_SIZE-1:0]         inst_in,
	input  rs_pkg::cdb_t [rs_pkg::SS_SIZE-1:0]            cdb_in,
	input  logic [rs_pkg::NUM_FU_TOTAL-1:0]               issue_stall,
	// Branch mispredict
	input  logic                                          flush,
	output rs_pkg::rs_row_t [rs_pkg::NUM_FU_TOTAL-1:0]    issue_out,
	output logic [rs_pkg::FREE_W-1:0]                     free_rows_next,
	output logic                                          rs_full
);

	//////////////////////////////
	// State and internals
	//////////////////////////////

	rs_pkg::rs_row_t [rs_pkg::RS_SIZE-1:0] rs_table;
	rs_pkg::rs_row_t [rs_pkg::RS_SIZE-1:0] rs_table_next;

	// CAM side
	logic [rs_pkg::SS_SIZE-1:0]                   cam_en;
	rs_pkg::phys_reg_t [rs_pkg::SS_SIZE-1:0]      cam_tags;
	rs_pkg::phys_reg_t [rs_pkg::RS_SIZE-1:0][1:0] cam_table;
	logic [rs_pkg::RS_SIZE-1:0][1:0]              cam_hits;

	// Dispatch side
	logic [rs_pkg::RS_SIZE-1:0]                         free_row;
	logic [rs_pkg::RS_SIZE-1:0]                         disp_gnt;
	logic [rs_pkg::SS_SIZE-1:0][rs_pkg::ROW_IDX_W-1:0]  disp_idx;
	logic [rs_pkg::SS_SIZE-1:0]                         disp_valid;
	logic [rs_pkg::SS_SIZE-1:0]                         lane_accept;
	logic [rs_pkg::SS_SIZE-1:0][rs_pkg::ROW_IDX_W-1:0]  lane_row;

	// Issue side
	logic [rs_pkg::RS_SIZE-1:0]                             row_ready;
	logic [rs_pkg::NUM_FU_TYPE-1:0][rs_pkg::RS_SIZE-1:0]    issue_req;
	logic [rs_pkg::NUM_FU_TOTAL-1:0][rs_pkg::ROW_IDX_W-1:0] slot_idx;
	logic [rs_pkg::NUM_FU_TOTAL-1:0]                        slot_valid;

	// Dispatch-time bypass against the live CDB
	function automatic logic cdb_hit(
		input rs_pkg::cdb_t [rs_pkg::SS_SIZE-1:0] cdb,
		input rs_pkg::phys_reg_t                  tag
	);
		logic hit;
		hit = 1'b0;
		for (int l = 0; l < rs_pkg::SS_SIZE; l++) begin
			if (cdb[l].valid && (cdb[l].tag == tag)) begin
				hit = 1'b1;
			end
		end
		return hit;
	endfunction

	//////////////////////////////
	// Wakeup CAM
	//////////////////////////////

	always_comb begin
		for (int l = 0; l < rs_pkg::SS_SIZE; l++) begin
			cam_en[l] = cdb_in[l].valid;
			cam_tags[l] = cdb_in[l].tag;
		end
		for (int r = 0; r < rs_pkg::RS_SIZE; r++) begin
			cam_table[r][0] = rs_table[r].t1.idx;
			cam_table[r][1] = rs_table[r].t2.idx;
		end
	end

	tag_cam #(
		.LENGTH  (rs_pkg::RS_SIZE),
		.NUM_TAGS(rs_pkg::SS_SIZE)
	) u_tag_cam (
		.cam_en    (cam_en),
		.tags      (cam_tags),
		.table_tags(cam_table),
		.hits      (cam_hits)
	);

	//////////////////////////////
	// Dispatch placement
	//////////////////////////////

	always_comb begin
		for (int r = 0; r < rs_pkg::RS_SIZE; r++) begin
			free_row[r] = ~rs_table[r].busy;
		end
	end

	// Always enabled so the grant union doubles as the not-full flag
	psel_generic #(
		.WIDTH   (rs_pkg::RS_SIZE),
		.NUM_REQS(rs_pkg::SS_SIZE)
	) u_psel_dispatch (
		.req      (free_row),
		.en       (1'b1),
		.gnt      (disp_gnt),
		.gnt_idx  (disp_idx),
		.gnt_valid(disp_valid)
	);

	assign rs_full = ~|disp_gnt;

	// Accepted lanes take free rows in lane order
	always_comb begin
		int rank;
		rank = 0;
		for (int l = 0; l < rs_pkg::SS_SIZE; l++) begin
			lane_row[l] = disp_idx[rank];
			lane_accept[l] = enable & dispatch_valid[l] & inst_in[l].valid_inst
				& disp_valid[rank];
			if (lane_accept[l]) begin
				rank++;
			end
		end
	end

	//////////////////////////////
	// Issue select
	//////////////////////////////

	// Ready counts this cycle's CDB hits too
	always_comb begin
		for (int r = 0; r < rs_pkg::RS_SIZE; r++) begin
			row_ready[r] = rs_table[r].busy
				& (rs_table[r].t1.ready | cam_hits[r][0])
				& (rs_table[r].t2.ready | cam_hits[r][1]);
			for (int k = 0; k < rs_pkg::NUM_FU_TYPE; k++) begin
				issue_req[k][r] = row_ready[r] & (rs_table[r].fu == rs_pkg::fu_type_e'(k));
			end
		end
	end

	for (genvar k = 0; k < rs_pkg::NUM_FU_TYPE; k++) begin : g_kind
		logic [rs_pkg::FU_COUNT[k]-1:0][rs_pkg::ROW_IDX_W-1:0] kind_gnt_idx;
		logic [rs_pkg::FU_COUNT[k]-1:0]                        kind_gnt_valid;
		logic [rs_pkg::FU_COUNT[k]-1:0][rs_pkg::ROW_IDX_W-1:0] kind_slot_idx;
		logic [rs_pkg::FU_COUNT[k]-1:0]                        kind_slot_valid;

		// One grant round per slot of this kind
		psel_generic #(
			.WIDTH   (rs_pkg::RS_SIZE),
			.NUM_REQS(rs_pkg::FU_COUNT[k])
		) u_psel_issue (
			.req      (issue_req[k]),
			.en       (enable),
			.gnt      (),
			.gnt_idx  (kind_gnt_idx),
			.gnt_valid(kind_gnt_valid)
		);

		// Open slots past a stall take grants in rank order
		always_comb begin
			int rank;
			rank = 0;
			for (int j = 0; j < rs_pkg::FU_COUNT[k]; j++) begin
				kind_slot_idx[j] = '0;
				kind_slot_valid[j] = 1'b0;
				if (!issue_stall[rs_pkg::FU_BASE_IDX[k] + j]) begin
					kind_slot_idx[j] = kind_gnt_idx[rank];
					kind_slot_valid[j] = kind_gnt_valid[rank];
					rank++;
				end
			end
		end

		for (genvar j = 0; j < rs_pkg::FU_COUNT[k]; j++) begin : g_slot
			assign slot_idx[rs_pkg::FU_BASE_IDX[k] + j] = kind_slot_idx[j];
			assign slot_valid[rs_pkg::FU_BASE_IDX[k] + j] = kind_slot_valid[j];
		end
	end

	// Issued copy shows both sources ready
	always_comb begin
		for (int s = 0; s < rs_pkg::NUM_FU_TOTAL; s++) begin
			issue_out[s] = rs_pkg::EMPTY_ROW;
			if (slot_valid[s]) begin
				issue_out[s] = rs_table[slot_idx[s]];
				issue_out[s].t1.ready = 1'b1;
				issue_out[s].t2.ready = 1'b1;
			end
		end
	end

	//////////////////////////////
	// Next table
	//////////////////////////////

	// Order is wakeup, issue, dispatch
	always_comb begin
		rs_table_next = rs_table;

		for (int r = 0; r < rs_pkg::RS_SIZE; r++) begin
			if (rs_table[r].busy) begin
				rs_table_next[r].t1.ready = rs_table[r].t1.ready | cam_hits[r][0];
				rs_table_next[r].t2.ready = rs_table[r].t2.ready | cam_hits[r][1];
			end
		end

		// Issued rows leave while stalled ones never got a slot
		for (int s = 0; s < rs_pkg::NUM_FU_TOTAL; s++) begin
			if (slot_valid[s]) begin
				rs_table_next[slot_idx[s]] = rs_pkg::EMPTY_ROW;
			end
		end

		// Only free rows are targets so no clash with issue
		for (int l = 0; l < rs_pkg::SS_SIZE; l++) begin
			if (lane_accept[l]) begin
				rs_table_next[lane_row[l]] = inst_in[l];
				rs_table_next[lane_row[l]].busy = 1'b1;
				rs_table_next[lane_row[l]].t1.ready =
					inst_in[l].t1.ready | cdb_hit(cdb_in, inst_in[l].t1.idx);
				rs_table_next[lane_row[l]].t2.ready =
					inst_in[l].t2.ready | cdb_hit(cdb_in, inst_in[l].t2.idx);
			end
		end
	end

	// Rows empty after the coming edge with flush freeing all
	always_comb begin
		free_rows_next = '0;
		for (int r = 0; r < rs_pkg::RS_SIZE; r++) begin
			free_rows_next = free_rows_next
				+ {{(rs_pkg::FREE_W - 1){1'b0}}, ~rs_table_next[r].busy};
		end
		if (flush) begin
			free_rows_next = rs_pkg::FREE_W'(rs_pkg::RS_SIZE);
		end
	end

	//////////////////////////////
	// Table register
	//////////////////////////////

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			rs_table <= {rs_pkg::RS_SIZE{rs_pkg::EMPTY_ROW}};
		end else if (flush) begin
			// Mispredict beats same-cycle dispatch
			rs_table <= {rs_pkg::RS_SIZE{rs_pkg::EMPTY_ROW}};
		end else begin
			rs_table <= rs_table_next;
		end
	end

endmodule

// File: src/rs_issue_top.sv
// Issue stage top level around the reservation station
`timescale 1ns/1ps

module rs_issue_top (
	input  logic                                          clock,
	input  logic                                          rst_n,
	// Reorder buffer dispatch permission
	input  logic                                          enable,
	input  logic [rs_pkg::SS_SIZE-1:0]                    dispatch_valid,
	input  rs_pkg::rs_row_t [rs_pkg::SS_SIZE-1:0]         inst_in,
	// Result tags from the CDB
	input  rs_pkg::cdb_t [rs_pkg::SS_SIZE-1:0]            cdb_in,
	// Per-slot back-pressure from the units
	input  logic [rs_pkg::NUM_FU_TOTAL-1:0]               issue_stall,
	input  logic                                          flush,
	// Slot order ALU0, ALU1, LD, MULT, BR
	output rs_pkg::rs_row_t [rs_pkg::NUM_FU_TOTAL-1:0]    issue_out,
	output logic [rs_pkg::FREE_W-1:0]                     free_rows_next,
	output logic                                          rs_full
);

	//////////////////////////////
	// Station
	//////////////////////////////

	reservation_station u_rs (
		.clock         (clock),
		.rst_n         (rst_n),
		.enable        (enable),
		.dispatch_valid(dispatch_valid),
		.inst_in       (inst_in),
		.cdb_in        (cdb_in),
		.issue_stall   (issue_stall),
		.flush         (flush),
		.issue_out     (issue_out),
		.free_rows_next(free_rows_next),
		.rs_full       (rs_full)
	);

endmodule

// File: verif/rs_checker.sv
// Issue stage checker for slot outputs, free count, full flag and the run summary
`timescale 1ns/1ps

module rs_checker (
	input  logic                                         clock,
	input  logic                                         check_en,
	input  int                                           line_no,
	// Expected values of the current stimulus line
	input  logic [rs_pkg::NUM_FU_TOTAL-1:0]              exp_busy,
	input  rs_pkg::phys_reg_t [rs_pkg::NUM_FU_TOTAL-1:0] exp_dest,
	input  logic [rs_pkg::FREE_W-1:0]                    exp_free,
	input  logic                                         exp_full,
	// Run status from the testbench
	input  logic                                         file_short,
	input  logic                                         timed_out,
	input  logic                                         run_done,
	// DUT outputs
	input  rs_pkg::rs_row_t [rs_pkg::NUM_FU_TOTAL-1:0]   issue_out,
	input  logic [rs_pkg::FREE_W-1:0]                    free_rows_next,
	input  logic                                         rs_full,
	output int                                           error_count
);

	// Sample 1.5 ns after the drive edge, just ahead of the rising edge
	localparam realtime SAMPLE_DELAY = 1.5;

	int   value_errors = 0;
	int   other_errors = 0;
	int   cycles_checked = 0;
	logic short_noted = 1'b0;
	logic timeout_noted = 1'b0;
	logic summary_done = 1'b0;

	assign error_count = value_errors + other_errors;

	task automatic report_mismatch(
		input string       name,
		input logic [31:0] expected,
		input logic [31:0] actual
	);
		$display("[ERROR] line %0d %s expected 0x%h got 0x%h", line_no, name, expected, actual);
		value_errors++;
	endtask

	//////////////////////////////
	// Per-cycle compare
	//////////////////////////////

	always @(negedge clock) begin
		#(SAMPLE_DELAY);
		if (check_en) begin
			cycles_checked++;
			for (int s = 0; s < rs_pkg::NUM_FU_TOTAL; s++) begin
				if (!exp_busy[s]) begin
					// Unused slot must carry the empty row
					if (issue_out[s] !== rs_pkg::EMPTY_ROW) begin
						report_mismatch($sformatf("issue_out[%0d]", s),
							32'(rs_pkg::EMPTY_ROW), 32'(issue_out[s]));
					end
				end else if (issue_out[s].busy !== 1'b1) begin
					report_mismatch($sformatf("issue_out[%0d].busy", s),
						32'h1, 32'(issue_out[s].busy));
				end else begin
					if (issue_out[s].dest !== exp_dest[s]) begin
						report_mismatch($sformatf("issue_out[%0d].dest", s),
							32'(exp_dest[s]), 32'(issue_out[s].dest));
					end
					// Issued copy shows both sources ready
					if ({issue_out[s].t1.ready, issue_out[s].t2.ready} !== 2'b11) begin
						report_mismatch($sformatf("issue_out[%0d] ready bits", s), 32'h3,
							32'({issue_out[s].t1.ready, issue_out[s].t2.ready}));
					end
				end
			end
			if (free_rows_next !== exp_free) begin
				report_mismatch("free_rows_next", 32'(exp_free), 32'(free_rows_next));
			end
			if (rs_full !== exp_full) begin
				report_mismatch("rs_full", 32'(exp_full), 32'(rs_full));
			end
		end

		// Run status
		if (file_short && !short_noted) begin
			$display("Stimulus file ended before line %0d, run stopped early", line_no);
			other_errors++;
			short_noted = 1'b1;
		end
		if (timed_out && !timeout_noted) begin
			$display("Watchdog expired before all stimulus lines were applied");
			other_errors++;
			timeout_noted = 1'b1;
		end
		if ((run_done || timed_out) && !summary_done) begin
			$display("Checked %0d cycles, %0d value errors, %0d other errors",
				cycles_checked, value_errors, other_errors);
			summary_done = 1'b1;
		end
	end

endmodule

// File: verif/rs_tb.sv
// Testbench top with clock, reset, watchdog, stimulus file driver, DUT and checker
`timescale 1ns/1ps

module rs_tb;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_LINES = 27;
	// Fourteen input fields, then eight expected fields
	localparam int NUM_FIELDS = 22;
	localparam int WATCHDOG_NS = NUM_LINES * CLK_PERIOD * 3 + RESET_CYCLES * CLK_PERIOD;

	logic                                       clock;
	logic                                       rst_n;
	logic                                       enable;
	logic [rs_pkg::SS_SIZE-1:0]                 dispatch_valid;
	rs_pkg::rs_row_t [rs_pkg::SS_SIZE-1:0]      inst_in;
	rs_pkg::cdb_t [rs_pkg::SS_SIZE-1:0]         cdb_in;
	logic [rs_pkg::NUM_FU_TOTAL-1:0]            issue_stall;
	logic                                       flush;
	rs_pkg::rs_row_t [rs_pkg::NUM_FU_TOTAL-1:0] issue_out;
	logic [rs_pkg::FREE_W-1:0]                  free_rows_next;
	logic                                       rs_full;

	// Checker side
	logic                                         check_en;
	int                                           line_no;
	logic [rs_pkg::NUM_FU_TOTAL-1:0]              exp_busy;
	rs_pkg::phys_reg_t [rs_pkg::NUM_FU_TOTAL-1:0] exp_dest;
	logic [rs_pkg::FREE_W-1:0]                    exp_free;
	logic                                         exp_full;
	logic                                         file_short;
	logic                                         timed_out;
	logic                                         run_done;
	int                                           error_count;

	// Whole file with NUM_FIELDS bytes per line
	logic [7:0] stim [NUM_LINES * NUM_FIELDS];

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	rs_issue_top i_rs_issue_top (
		.clock         (clock),
		.rst_n         (rst_n),
		.enable        (enable),
		.dispatch_valid(dispatch_valid),
		.inst_in       (inst_in),
		.cdb_in        (cdb_in),
		.issue_stall   (issue_stall),
		.flush         (flush),
		.issue_out     (issue_out),
		.free_rows_next(free_rows_next),
		.rs_full       (rs_full)
	);

	rs_checker u_checker (
		.clock         (clock),
		.check_en      (check_en),
		.line_no       (line_no),
		.exp_busy      (exp_busy),
		.exp_dest      (exp_dest),
		.exp_free      (exp_free),
		.exp_full      (exp_full),
		.file_short    (file_short),
		.timed_out     (timed_out),
		.run_done      (run_done),
		.issue_out     (issue_out),
		.free_rows_next(free_rows_next),
		.rs_full       (rs_full),
		.error_count   (error_count)
	);

	//////////////////////////////
	// Line decoding
	//////////////////////////////

	// Source fields carry the ready flag in bit 5
	function automatic rs_pkg::rs_row_t make_row(
		input logic [7:0] fu,
		input logic [7:0] dest,
		input logic [7:0] src1,
		input logic [7:0] src2,
		input logic       valid
	);
		rs_pkg::rs_row_t row;
		row = rs_pkg::EMPTY_ROW;
		row.fu = rs_pkg::fu_type_e'(fu[1:0]);
		row.dest = dest[4:0];
		row.t1 = src1[5:0];
		row.t2 = src2[5:0];
		row.valid_inst = valid;
		return row;
	endfunction

	// Quiet cycle with enable low so the table holds
	task automatic drive_idle();
		enable = 1'b0;
		flush = 1'b0;
		dispatch_valid = '0;
		inst_in = '0;
		cdb_in = '0;
		issue_stall = '0;
		check_en = 1'b0;
		exp_busy = '0;
		exp_dest = '0;
		exp_free = '0;
		exp_full = 1'b0;
	endtask

	task automatic drive_line(input int n);
		int b;
		b = n * NUM_FIELDS;
		enable = stim[b][0];
		flush = stim[b + 1][0];
		dispatch_valid = stim[b + 2][1:0];
		inst_in[0] = make_row(stim[b + 3], stim[b + 4], stim[b + 5], stim[b + 6], stim[b + 2][0]);
		inst_in[1] = make_row(stim[b + 7], stim[b + 8], stim[b + 9], stim[b + 10], stim[b + 2][1]);
		cdb_in[0] = stim[b + 11][5:0];
		cdb_in[1] = stim[b + 12][5:0];
		issue_stall = stim[b + 13][4:0];
		exp_busy = stim[b + 14][4:0];
		for (int s = 0; s < rs_pkg::NUM_FU_TOTAL; s++) begin
			exp_dest[s] = stim[b + 15 + s][4:0];
		end
		exp_free = stim[b + 20][3:0];
		exp_full = stim[b + 21][0];
		line_no = n;
		check_en = 1'b1;
	endtask

	//////////////////////////////
	// Stimulus and end of run
	//////////////////////////////

	initial begin
		void'($urandom(32'h5d45));
		rst_n = 1'b0;
		drive_idle();
		line_no = 0;
		file_short = 1'b0;
		run_done = 1'b0;
		// Marker fill above 8'h01 that every loaded line overwrites
		for (int i = 0; i < NUM_LINES * NUM_FIELDS; i++) begin
			stim[i] = {1'b1, 7'(i ^ (i >> 7))};
		end
		$readmemh("verif/rs_stimulus.mem", stim);

		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;

		for (int n = 0; n < NUM_LINES && !file_short; n++) begin
			@(negedge clock);
			// Occasional idle gap between lines
			if ($urandom % 4 == 0) begin
				drive_idle();
				@(negedge clock);
			end
			// Marker left in the last field means the file is short
			if (stim[n * NUM_FIELDS + NUM_FIELDS - 1] > 8'h01) begin
				drive_idle();
				line_no = n;
				file_short = 1'b1;
			end else begin
				drive_line(n);
			end
		end
		if (!file_short) begin
			@(negedge clock);
			drive_idle();
		end
		run_done = 1'b1;

		// Checker has printed its summary by the next rising edge
		@(posedge clock);
		if (error_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	// Watchdog sized from the line count
	initial begin
		timed_out = 1'b0;
		#(WATCHDOG_NS);
		@(negedge clock);
		timed_out = 1'b1;
		@(posedge clock);
		$display("Test failures found");
		$finish;
	end

endmodule

// File: verif/rs_stimulus.mem
// en fl dv | lane0 fu dest src1 src2 | lane1 fu dest src1 src2 | cdb0 cdb1 stall |
// exp busy mask, exp dest slot0..slot4, exp free_rows_next, exp rs_full (src bit5 ready)
// Reset state
01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 08 00
// Ready pairs, ALU into slots 0 and 1, then LD and BR
01 00 03 00 01 21 22 00 02 23 24 00 00 00 00 00 00 00 00 00 06 00
01 00 03 01 03 21 22 03 04 23 24 00 00 00 03 01 02 00 00 00 06 00
01 00 00 00 00 00 00 00 00 00 00 00 00 00 14 00 00 03 00 04 08 00
// Wakeup on tag 7 and bypass on tag 9
01 00 03 02 05 07 21 00 06 09 22 29 00 00 00 00 00 00 00 00 06 00
01 00 00 00 00 00 00 00 00 00 00 00 00 00 01 06 00 00 00 00 07 00
01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 07 00
01 00 00 00 00 00 00 00 00 00 00 00 27 00 08 00 00 00 05 00 08 00
// Stall shifting on ALU slot 0, then a stalled load slot
01 00 03 00 0A 21 22 00 0B 21 22 00 00 00 00 00 00 00 00 00 06 00
01 00 03 01 0C 21 22 00 0D 0F 22 00 00 01 02 00 0A 00 00 00 05 00
01 00 00 00 00 00 00 00 00 00 00 00 00 04 01 0B 00 00 00 00 06 00
01 00 00 00 00 00 00 00 00 00 00 00 00 00 04 00 00 0C 00 00 07 00
01 00 00 00 00 00 00 00 00 00 00 2F 00 00 01 0D 00 00 00 00 08 00
// Eight waiting rows fill the table
01 00 03 00 11 10 21 01 12 10 21 00 00 00 00 00 00 00 00 00 06 00
01 00 03 02 13 11 21 03 14 11 21 00 00 00 00 00 00 00 00 00 04 00
01 00 03 00 15 12 21 00 16 12 21 00 00 00 00 00 00 00 00 00 02 00
01 00 03 01 17 13 21 00 18 13 21 00 00 00 00 00 00 00 00 00 00 00
01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 01
01 00 00 00 00 00 00 00 00 00 00 30 32 00 07 11 15 12 00 00 03 01
01 00 00 00 00 00 00 00 00 00 00 31 00 00 19 16 00 00 13 14 06 00
// Enable low still wakes up, then flush beats dispatch
00 00 01 00 1A 21 22 00 00 00 00 33 00 00 00 00 00 00 00 00 06 00
01 00 00 00 00 00 00 00 00 00 00 00 00 00 05 18 00 17 00 00 08 00
01 00 03 00 1B 14 21 00 1C 14 21 00 00 00 00 00 00 00 00 00 06 00
01 01 01 00 1D 21 22 00 00 00 00 00 00 00 00 00 00 00 00 00 08 00
01 00 00 00 00 00 00 00 00 00 00 34 00 00 00 00 00 00 00 00 08 00
01 00 01 00 1E 21 22 00 00 00 00 00 00 00 00 00 00 00 00 00 07 00
01 00 00 00 00 00 00 00 00 00 00 00 00 00 01 1E 00 00 00 00 08 00

// File: all.f
src/rs_pkg.sv
src/psel_generic.sv
src/tag_cam.sv
src/reservation_station.sv
src/rs_issue_top.sv
verif/rs_checker.sv
verif/rs_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := rs_tb
FILELIST   := all.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := All tests passed!
FLAGS      := --binary --timing --timescale 1ns/1ps --top-module $(TOP)
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/1ps --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
